/* compile.f */
design/rx_mem_pkg.sv
design/rx_access_pkg.sv
design/rx_mem_if.sv
design/packet_writer.sv
design/rx_ram.sv
design/access_reader.sv
design/nts_rx_buffer.sv
sim/tb_nts_rx_buffer.sv

/* Bender.yml */
package:
  name: nts_rx_buffer

sources:
  - design/rx_mem_pkg.sv
  - design/rx_access_pkg.sv
  - design/rx_mem_if.sv
  - design/packet_writer.sv
  - design/rx_ram.sv
  - design/access_reader.sv
  - design/nts_rx_buffer.sv
  - target: simulation
    files:
      - sim/tb_nts_rx_buffer.sv

/* sim/tb_nts_rx_buffer.sv */
/*
  Testbench for the receive buffer with a dispatch FIFO model.
  Random reads stay inside the filled words, so no read touches
  uninitialized RAM. Inputs change on the falling clock edge only.
*/

`timescale 1ns/1ps

module tb_nts_rx_buffer;

  logic                      i_clk;
  logic                      i_areset;
  logic                      i_parser_busy;
  logic                      i_dispatch_packet_available;
  logic                      o_dispatch_packet_read;
  logic                      i_dispatch_fifo_empty;
  logic                      o_dispatch_fifo_rd_start;
  logic                      i_dispatch_fifo_rd_valid;
  rx_mem_pkg::word_t         i_dispatch_fifo_rd_data;
  logic                      o_access_port_wait;
  rx_mem_pkg::byte_addr_t    i_access_port_addr;
  rx_access_pkg::word_size_e i_access_port_wordsize;
  logic                      i_access_port_rd_en;
  logic                      o_access_port_rd_dv;
  rx_mem_pkg::word_t         o_access_port_rd_data;

  rx_mem_pkg::word_t image [0:(2**rx_mem_pkg::ADDR_WIDTH)-1];
  rx_mem_pkg::word_t fifo_q [$];
  rx_mem_pkg::word_t exp_q [$];

  int errors = 0;
  int timeouts = 0;
  int checked = 0;
  int rd_start_count = 0;
  int packet_read_count = 0;

  nts_rx_buffer UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // --------------------------------------------------
  // Compare tasks and reference model
  // --------------------------------------------------

  task automatic check_word(input string name, input rx_mem_pkg::word_t got,
                            input rx_mem_pkg::word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Big-endian bytes from the image, 32-bit values land in the low half
  function automatic rx_mem_pkg::word_t expected_value(input rx_mem_pkg::byte_addr_t addr,
                                                       input rx_access_pkg::word_size_e ws);
    rx_mem_pkg::word_t      res;
    rx_mem_pkg::byte_addr_t b;
    rx_mem_pkg::word_addr_t w;
    int                     nbytes;
    res = '0;
    nbytes = (ws == rx_access_pkg::WS_32) ? 4 : 8;
    for (int i = 0; i < nbytes; i++) begin
      b = rx_mem_pkg::byte_addr_t'(addr + i);
      w = b[rx_mem_pkg::OFFSET_WIDTH +: rx_mem_pkg::ADDR_WIDTH];
      res[8*(nbytes-1-i) +: 8] = image[w][8*(7-b[2:0]) +: 8];
    end
    return res;
  endfunction

  // --------------------------------------------------
  // Dispatch FIFO model and output monitors
  // --------------------------------------------------

  initial begin : fifo_model
    logic streaming;
    streaming = 1'b0;
    i_dispatch_packet_available = 1'b0;
    i_dispatch_fifo_empty = 1'b1;
    i_dispatch_fifo_rd_valid = 1'b0;
    i_dispatch_fifo_rd_data = '0;
    forever begin
      @(negedge i_clk);
      if (streaming) begin
        if (fifo_q.size() > 0) begin
          i_dispatch_fifo_rd_valid = 1'b1;
          i_dispatch_fifo_rd_data = fifo_q.pop_front();
          i_dispatch_fifo_empty = (fifo_q.size() == 0);
        end else begin
          i_dispatch_fifo_rd_valid = 1'b0;
          i_dispatch_fifo_empty = 1'b1;
          streaming = 1'b0;
        end
      end else if (o_dispatch_fifo_rd_start) begin
        // First word follows one cycle after the start pulse
        streaming = 1'b1;
        i_dispatch_packet_available = 1'b0;
      end else begin
        i_dispatch_fifo_empty = (fifo_q.size() == 0);
        i_dispatch_packet_available = (fifo_q.size() > 0);
      end
    end
  end

  always @(negedge i_clk) begin
    if (o_dispatch_fifo_rd_start) rd_start_count++;
    if (o_dispatch_packet_read) packet_read_count++;
  end

  always @(negedge i_clk) begin
    if (o_access_port_rd_dv) begin
      if (exp_q.size() == 0) begin
        $display("rd_dv pulsed with no read outstanding");
        errors++;
      end else begin
        check_word("o_access_port_rd_data", o_access_port_rd_data, exp_q.pop_front());
        checked++;
      end
    end
  end

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------

  task automatic load_packet(input int n_words);
    rx_mem_pkg::word_t w;
    for (int i = 0; i < n_words; i++) begin
      w = {$urandom, $urandom};
      fifo_q.push_back(w);
      image[i] = w;
    end
  endtask

  task automatic wait_for_fill(input int fill_no);
    int cycles;
    cycles = 0;
    while (rd_start_count < fill_no && cycles < 40) begin
      @(negedge i_clk);
      cycles++;
    end
    if (rd_start_count < fill_no) begin
      $display("TIMEOUT: no rd_start pulse for fill %0d", fill_no);
      timeouts++;
    end
    cycles = 0;
    while (packet_read_count < fill_no && cycles < 200) begin
      @(negedge i_clk);
      cycles++;
    end
    if (packet_read_count < fill_no) begin
      $display("TIMEOUT: no packet_read pulse for fill %0d", fill_no);
      timeouts++;
    end
    repeat (5) @(negedge i_clk);
    if (rd_start_count != fill_no || packet_read_count != fill_no) begin
      $display("Fill %0d gave %0d rd_start and %0d packet_read pulses in total",
               fill_no, rd_start_count, packet_read_count);
      errors++;
    end
  endtask

  task automatic read_and_check(input rx_mem_pkg::byte_addr_t addr,
                                input rx_access_pkg::word_size_e ws);
    int   edges;
    int   exp_edges;
    int   nbytes;
    logic spans;
    // Two words are needed when the last byte lies past the end of the word
    nbytes = (ws == rx_access_pkg::WS_32) ? 4 : 8;
    spans = (int'(addr[2:0]) + nbytes) > rx_mem_pkg::BYTES_PER_WORD;
    exp_edges = spans ? 4 : 3;
    @(negedge i_clk);
    i_access_port_addr = addr;
    i_access_port_wordsize = ws;
    i_access_port_rd_en = 1'b1;
    exp_q.push_back(expected_value(addr, ws));
    @(negedge i_clk);
    i_access_port_rd_en = 1'b0;
    edges = 1;
    while (!o_access_port_rd_dv && edges < 10) begin
      check_flag("o_access_port_wait", o_access_port_wait, 1'b1);
      @(negedge i_clk);
      edges++;
    end
    if (!o_access_port_rd_dv) begin
      $display("TIMEOUT: no rd_dv for the read at byte address 0x%h", addr);
      timeouts++;
    end else begin
      check_flag("o_access_port_wait", o_access_port_wait, 1'b0);
      if (edges != exp_edges) begin
        $display("Read at byte address 0x%h finished after %0d edges instead of %0d",
                 addr, edges, exp_edges);
        errors++;
      end
    end
  endtask

  task automatic ignored_request(input rx_access_pkg::word_size_e ws);
    @(negedge i_clk);
    i_access_port_addr = rx_mem_pkg::byte_addr_t'(8);
    i_access_port_wordsize = ws;
    i_access_port_rd_en = 1'b1;
    @(negedge i_clk);
    i_access_port_rd_en = 1'b0;
    repeat (10) begin
      check_flag("o_access_port_wait", o_access_port_wait, 1'b0);
      check_flag("o_access_port_rd_dv", o_access_port_rd_dv, 1'b0);
      @(negedge i_clk);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    int                        word_sel;
    int                        off_sel;
    rx_access_pkg::word_size_e ws_sel;
    void'($urandom(81));
    i_areset = 1'b1;
    i_parser_busy = 1'b1;
    i_access_port_rd_en = 1'b0;
    i_access_port_addr = '0;
    i_access_port_wordsize = rx_access_pkg::WS_64;
    repeat (16) @(negedge i_clk);
    i_areset = 1'b0;

    // Parser busy holds the fill back
    load_packet(32);
    repeat (20) @(negedge i_clk);
    check_flag("o_dispatch_fifo_rd_start", rd_start_count != 0, 1'b0);
    i_parser_busy = 1'b0;
    wait_for_fill(1);

    for (int i = 0; i < 32; i++) begin
      read_and_check(rx_mem_pkg::byte_addr_t'(i * rx_mem_pkg::BYTES_PER_WORD),
                     rx_access_pkg::WS_64);
    end

    // Second word must stay inside the packet
    for (int i = 0; i < 60; i++) begin
      word_sel = $urandom_range(30, 0);
      off_sel = $urandom_range(7, 0);
      ws_sel = ($urandom_range(1, 0) == 0) ? rx_access_pkg::WS_32 : rx_access_pkg::WS_64;
      read_and_check(rx_mem_pkg::byte_addr_t'(word_sel * rx_mem_pkg::BYTES_PER_WORD + off_sel),
                     ws_sel);
    end

    ignored_request(rx_access_pkg::WS_8);
    ignored_request(rx_access_pkg::WS_16);
    ignored_request(rx_access_pkg::WS_BURST);

    // Shorter packet overwrites the low words only
    load_packet(12);
    wait_for_fill(2);
    for (int i = 0; i < 32; i++) begin
      read_and_check(rx_mem_pkg::byte_addr_t'(i * rx_mem_pkg::BYTES_PER_WORD),
                     rx_access_pkg::WS_64);
    end

    repeat (5) @(negedge i_clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected read results never arrived", exp_q.size());
      errors++;
    end
    $display("Errors: %0d, timeouts: %0d, results checked: %0d", errors, timeouts, checked);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* design/nts_rx_buffer.sv */
/*
  Receive buffer of the time-protocol front end.
  Packets are copied from the dispatch FIFO into RAM starting at word 0,
  then read back through the access port as 32-bit or 64-bit values.
  There is no back-pressure, so rd_en is only valid while wait is low.
*/

`timescale 1ns/1ps

module nts_rx_buffer (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_parser_busy,
  input  logic                      i_dispatch_packet_available,
  output logic                      o_dispatch_packet_read,
  input  logic                      i_dispatch_fifo_empty,
  output logic                      o_dispatch_fifo_rd_start,
  input  logic                      i_dispatch_fifo_rd_valid,
  input  rx_mem_pkg::word_t         i_dispatch_fifo_rd_data,
  output logic                      o_access_port_wait,
  input  rx_mem_pkg::byte_addr_t    i_access_port_addr,
  input  rx_access_pkg::word_size_e i_access_port_wordsize,
  input  logic                      i_access_port_rd_en,
  output logic                      o_access_port_rd_dv,
  output rx_mem_pkg::word_t         o_access_port_rd_data
);

  logic reader_idle;
  logic fill_active;

  rx_mem_if mem_bus ();

  // Fill path from the dispatch FIFO
  packet_writer u_packet_writer (
    .i_clk                       (i_clk),
    .i_areset                    (i_areset),
    .i_parser_busy               (i_parser_busy),
    .i_dispatch_packet_available (i_dispatch_packet_available),
    .i_dispatch_fifo_empty       (i_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_valid    (i_dispatch_fifo_rd_valid),
    .i_dispatch_fifo_rd_data     (i_dispatch_fifo_rd_data),
    .i_reader_idle               (reader_idle),
    .o_fill_active               (fill_active),
    .o_dispatch_fifo_rd_start    (o_dispatch_fifo_rd_start),
    .o_dispatch_packet_read      (o_dispatch_packet_read),
    .mem                         (mem_bus.writer)
  );

  rx_ram u_rx_ram (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .mem      (mem_bus.memory)
  );

  // Access port
  access_reader u_access_reader (
    .i_clk                  (i_clk),
    .i_areset               (i_areset),
    .i_fill_active          (fill_active),
    .i_access_port_rd_en    (i_access_port_rd_en),
    .i_access_port_addr     (i_access_port_addr),
    .i_access_port_wordsize (i_access_port_wordsize),
    .o_idle                 (reader_idle),
    .o_access_port_wait     (o_access_port_wait),
    .o_access_port_rd_dv    (o_access_port_rd_dv),
    .o_access_port_rd_data  (o_access_port_rd_data),
    .mem                    (mem_bus.reader)
  );

endmodule

/* design/access_reader.sv */
/*
  Serves 32-bit and 64-bit reads at any byte address of the buffer.
  A value inside one word is ready three edges after rd_en, a value
  spanning two words four edges after it. The second word wraps to 0.
  Requests with other word sizes, during a fill or while busy are ignored.
*/

`timescale 1ns/1ps

module access_reader (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_fill_active,
  input  logic                      i_access_port_rd_en,
  input  rx_mem_pkg::byte_addr_t    i_access_port_addr,
  input  rx_access_pkg::word_size_e i_access_port_wordsize,
  output logic                      o_idle,
  output logic                      o_access_port_wait,
  output logic                      o_access_port_rd_dv,
  output rx_mem_pkg::word_t         o_access_port_rd_data,
  rx_mem_if.reader                  mem
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SINGLE_DLY,
    ST_SINGLE,
    ST_FIRST_DLY,
    ST_FIRST,
    ST_SECOND
  } reader_state_e;

  reader_state_e               state_q;
  reader_state_e               state_d;
  logic                        idle_q;
  logic                        wait_q;
  logic                        dv_q;
  rx_access_pkg::byte_offset_t req_offset;
  logic                        ws_ok;
  logic                        req_accept;
  logic                        req_spans;
  logic                        finish;

  rx_mem_pkg::word_addr_t      addr_q;
  rx_access_pkg::byte_offset_t offset_q;
  rx_access_pkg::word_size_e   ws_q;
  rx_mem_pkg::word_t           first_q;
  rx_mem_pkg::word_t           rd_data_q;

  rx_mem_pkg::word_t                   hi_word;
  rx_mem_pkg::word_t                   lo_word;
  logic [2*rx_mem_pkg::WORD_WIDTH-1:0] pair_shifted;
  rx_mem_pkg::word_t                   aligned;
  rx_mem_pkg::word_t                   result;

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------

  assign req_offset = i_access_port_addr[rx_mem_pkg::OFFSET_WIDTH-1:0];
  assign ws_ok      = (i_access_port_wordsize == rx_access_pkg::WS_32) ||
                      (i_access_port_wordsize == rx_access_pkg::WS_64);
  assign req_accept = i_access_port_rd_en && (state_q == ST_IDLE) && !i_fill_active && ws_ok;

  // Four bytes fit from offsets 0 to 4, eight bytes only from offset 0
  assign req_spans  = (i_access_port_wordsize == rx_access_pkg::WS_32) ?
                      (req_offset >= rx_access_pkg::byte_offset_t'(5)) :
                      (req_offset != '0);

  assign finish = (state_q == ST_SINGLE) || (state_q == ST_SECOND);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_accept) begin
          state_d = req_spans ? ST_FIRST_DLY : ST_SINGLE_DLY;
        end
      end
      ST_SINGLE_DLY: state_d = ST_SINGLE;
      ST_SINGLE:     state_d = ST_IDLE;
      ST_FIRST_DLY:  state_d = ST_FIRST;
      ST_FIRST:      state_d = ST_SECOND;
      ST_SECOND:     state_d = ST_IDLE;
      default:       state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= ST_IDLE;
      idle_q  <= 1'b1;
      wait_q  <= 1'b0;
      dv_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      idle_q  <= (state_d == ST_IDLE);
      wait_q  <= req_accept || (wait_q && !finish);
      dv_q    <= finish;
    end
  end

  // --------------------------------------------------
  // Address, request fields and result
  // --------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (req_accept) begin
      addr_q   <= i_access_port_addr[rx_mem_pkg::OFFSET_WIDTH +: rx_mem_pkg::ADDR_WIDTH];
      offset_q <= req_offset;
      ws_q     <= i_access_port_wordsize;
    end else if (state_q == ST_FIRST_DLY) begin
      // First word already sampled by the RAM on this edge
      addr_q   <= rx_mem_pkg::word_addr_t'(addr_q + 1'b1);
    end
    if (state_q == ST_FIRST) begin
      first_q <= mem.rd_data;
    end
    if (finish) begin
      rd_data_q <= result;
    end
  end

  assign mem.rd_addr = addr_q;

  // Big-endian join, first word moved up by the offset, second fills below
  assign hi_word      = (state_q == ST_SECOND) ? first_q : mem.rd_data;
  assign lo_word      = (state_q == ST_SECOND) ? mem.rd_data : '0;
  assign pair_shifted = {hi_word, lo_word} << {offset_q, 3'b000};
  assign aligned      = pair_shifted[2*rx_mem_pkg::WORD_WIDTH-1 -: rx_mem_pkg::WORD_WIDTH];

  // 32-bit values sit in the low half
  assign result = (ws_q == rx_access_pkg::WS_32) ?
                  {{(rx_mem_pkg::WORD_WIDTH/2){1'b0}},
                   aligned[rx_mem_pkg::WORD_WIDTH-1 -: rx_mem_pkg::WORD_WIDTH/2]} :
                  aligned;

  assign o_idle                = idle_q;
  assign o_access_port_wait    = wait_q;
  assign o_access_port_rd_dv   = dv_q;
  assign o_access_port_rd_data = rd_data_q;

endmodule

/* design/rx_ram.sv */
/*
  Single-clock buffer RAM with one write port and one registered read port.
  Read latency is one cycle and a read during a write returns the old word.
  The array has no reset, only the read register is cleared.
*/

`timescale 1ns/1ps

module rx_ram (
  input  logic     i_clk,
  input  logic     i_areset,
  rx_mem_if.memory mem
);

  rx_mem_pkg::word_t mem_array [0:(2**rx_mem_pkg::ADDR_WIDTH)-1];
  rx_mem_pkg::word_t rd_data_q;

  logic sync_meta_q;
  logic sync_reset_q;

  // --------------------------------------------------
  // Reset synchronizer
  // --------------------------------------------------

  // Asserts with i_areset, releases two edges after it
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      sync_meta_q  <= 1'b1;
      sync_reset_q <= 1'b1;
    end else begin
      sync_meta_q  <= 1'b0;
      sync_reset_q <= sync_meta_q;
    end
  end

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (mem.wr_en) begin
      mem_array[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Registered read port, cleared by the synchronized reset
  always_ff @(posedge i_clk) begin
    if (sync_reset_q) begin
      rd_data_q <= '0;
    end else begin
      rd_data_q <= mem_array[mem.rd_addr];
    end
  end

  assign mem.rd_data = rd_data_q;

endmodule

/* design/packet_writer.sv */
/*
  Copies one packet from the dispatch FIFO into the buffer RAM from word 0.
  A fill only starts while the parser is not busy and the reader is idle.
  The FIFO is assumed to present one word per rd_valid cycle with no stall.
*/

`timescale 1ns/1ps

module packet_writer (
  input  logic              i_clk,
  input  logic              i_areset,
  input  logic              i_parser_busy,
  input  logic              i_dispatch_packet_available,
  input  logic              i_dispatch_fifo_empty,
  input  logic              i_dispatch_fifo_rd_valid,
  input  rx_mem_pkg::word_t i_dispatch_fifo_rd_data,
  input  logic              i_reader_idle,
  output logic              o_fill_active,
  output logic              o_dispatch_fifo_rd_start,
  output logic              o_dispatch_packet_read,
  rx_mem_if.writer          mem
);

  typedef enum logic {
    ST_IDLE,
    ST_FILL
  } writer_state_e;

  writer_state_e          state_q;
  rx_mem_pkg::word_addr_t fill_addr_q;
  logic                   fill_start;
  logic                   fill_done;
  logic                   word_valid;
  logic                   rd_start_q;
  logic                   packet_read_q;

  // --------------------------------------------------
  // Start and end conditions
  // --------------------------------------------------

  assign fill_start = (state_q == ST_IDLE) && i_dispatch_packet_available &&
                      !i_dispatch_fifo_empty && !i_parser_busy && i_reader_idle;

  // FIFO drained once no word is valid and the FIFO reports empty
  assign fill_done  = (state_q == ST_FILL) && !i_dispatch_fifo_rd_valid &&
                      i_dispatch_fifo_empty;

  assign word_valid = (state_q == ST_FILL) && i_dispatch_fifo_rd_valid;

  // Also high in the start cycle so that a read request there is dropped
  assign o_fill_active = fill_start || (state_q != ST_IDLE);

  // --------------------------------------------------
  // FSM, address counter and FIFO strobes
  // --------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q       <= ST_IDLE;
      fill_addr_q   <= '0;
      rd_start_q    <= 1'b0;
      packet_read_q <= 1'b0;
    end else begin
      rd_start_q    <= fill_start;
      packet_read_q <= fill_done;
      if (fill_start) begin
        state_q     <= ST_FILL;
        fill_addr_q <= '0;
      end else if (fill_done) begin
        state_q     <= ST_IDLE;
      end
      if (word_valid) begin
        fill_addr_q <= rx_mem_pkg::word_addr_t'(fill_addr_q + 1'b1);
      end
    end
  end

  assign o_dispatch_fifo_rd_start = rd_start_q;
  assign o_dispatch_packet_read   = packet_read_q;

  // Each valid FIFO word goes straight to the current fill address
  assign mem.wr_en   = word_valid;
  assign mem.wr_addr = fill_addr_q;
  assign mem.wr_data = i_dispatch_fifo_rd_data;

endmodule

/* design/rx_mem_if.sv */
/*
  Connection between the packet writer, the buffer RAM and the access reader.
  Read data is the word at rd_addr sampled on the previous clock edge.
  A write and a read of the same word in one cycle return the old data.
*/

`timescale 1ns/1ps

interface rx_mem_if;

  // Write side, driven by the packet writer
  logic                   wr_en;
  rx_mem_pkg::word_addr_t wr_addr;
  rx_mem_pkg::word_t      wr_data;

  // Read side
  rx_mem_pkg::word_addr_t rd_addr;
  rx_mem_pkg::word_t      rd_data;

  modport writer (output wr_en, output wr_addr, output wr_data);

  modport reader (output rd_addr, input rd_data);

  modport memory (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

/* design/rx_access_pkg.sv */
/*
  Access-port protocol definitions.
  The word-size code keeps the full encoding of the port, but only
  WS_32 and WS_64 are served. Other codes are ignored by the reader.
*/

package rx_access_pkg;

  // Word-size code as driven on the access port
  typedef enum logic [2:0] {
    WS_8     = 3'd0,
    WS_16    = 3'd1,
    WS_32    = 3'd2,
    WS_64    = 3'd3,
    WS_BURST = 3'd4
  } word_size_e;

  // Byte position of a read inside one RAM word
  typedef logic [rx_mem_pkg::OFFSET_WIDTH-1:0] byte_offset_t;

endpackage

/* design/rx_mem_pkg.sv */
/*
  Geometry of the receive buffer RAM and the types built on it.
  One RAM word holds eight bytes, stored big-endian, so byte 0 is bits 63:56.
  A byte address is a word address followed by the byte offset in that word.
*/

package rx_mem_pkg;

  localparam int unsigned ADDR_WIDTH     = 8;
  localparam int unsigned WORD_WIDTH     = 64;
  localparam int unsigned BYTES_PER_WORD = 8;
  localparam int unsigned OFFSET_WIDTH   = $clog2(BYTES_PER_WORD);

  // RAM word, also the width of an access result
  typedef logic [WORD_WIDTH-1:0] word_t;

  typedef logic [ADDR_WIDTH-1:0] word_addr_t;

  // Word address in the upper bits, byte offset in the lower bits
  typedef logic [ADDR_WIDTH+OFFSET_WIDTH-1:0] byte_addr_t;

endpackage
